// File: Makefile
TOP := tb_rvc_expander

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing check"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f build.f -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

// File: build.f
rv32_pkg.sv
rvc_pkg.sv
rvc_expand_if.sv
rvc_fetch_stage.sv
rvc_q0_expander.sv
rvc_q1_expander.sv
rvc_q2_expander.sv
rvc_issue_stage.sv
rvc_expander_top.sv
rvc_expander_asserts.sv
rvc_checker.sv
tb_rvc_expander.sv

// File: rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT_W   = 3'b010, // LW and SW share this code
        XOR     = 3'b100,
        SR      = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } f3_e;

    // Branch codes reuse the ALU funct3 values
    localparam f3_e BEQ = ADD_SUB;
    localparam f3_e BNE = SLL;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRAI

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    localparam word_t EBREAK_WORD = {12'h001, REG_ZERO, 3'b000, REG_ZERO, SYSTEM};

endpackage

`default_nettype wire

// File: rvc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_checker (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_valid,
    input  rv32_pkg::word_t i_instr,
    input  logic            i_is_compressed,
    input  logic            i_illegal,
    output int              o_checked,
    output int              o_errors
);
    import rv32_pkg::*;

    string exp_name[$];
    word_t exp_instr[$];
    logic  exp_comp[$];
    logic  exp_ill[$];
    int    exp_edge[$];
    int    edge_count = 0;
    int    checked    = 0;
    int    errors     = 0;

    assign o_checked = checked;
    assign o_errors  = errors;

    task automatic expect_word(input string name, input word_t instr,
                               input logic comp, input logic ill);
        exp_name.push_back(name);
        exp_instr.push_back(instr);
        exp_comp.push_back(comp);
        exp_ill.push_back(ill);
        exp_edge.push_back(edge_count);
    endtask

    task automatic fail_check(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // Outputs settle after the rising edge, sampled on the falling one
    always @(negedge i_clk) begin
        string name;
        word_t want;
        logic  want_comp;
        logic  want_ill;
        int    lag;
        bit    ok;
        edge_count = edge_count + 1;
        if (i_valid && exp_instr.size() == 0) begin
            errors++;
            $display("Unexpected output: o_valid high at %0t with no word in flight (reset %0b)",
                     $time, i_rst);
        end else if (i_valid) begin
            name      = exp_name.pop_front();
            want      = exp_instr.pop_front();
            want_comp = exp_comp.pop_front();
            want_ill  = exp_ill.pop_front();
            lag       = edge_count - exp_edge.pop_front(); // Driven one edge before entry
            ok        = 1'b1;
            if (lag != 3) begin
                fail_check($sformatf("%s came out %0d cycles after entry", name, lag - 1));
                ok = 1'b0;
            end
            if (i_instr !== want) begin
                fail_check($sformatf("%s word %08h, expected %08h", name, i_instr, want));
                ok = 1'b0;
            end
            if (i_is_compressed !== want_comp) begin
                fail_check($sformatf("%s is_compressed %0b, expected %0b",
                                     name, i_is_compressed, want_comp));
                ok = 1'b0;
            end
            if (i_illegal !== want_ill) begin
                fail_check($sformatf("%s illegal %0b, expected %0b", name, i_illegal, want_ill));
                ok = 1'b0;
            end
            checked++;
            $display("%s %-14s out=%08h comp=%0b illegal=%0b", ok ? "PASS" : "FAIL",
                     name, i_instr, i_is_compressed, i_illegal);
        end
    end

endmodule

`default_nettype wire

// File: rvc_expand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rvc_expand_if;
    import rv32_pkg::*;

    word_t q0_instr;
    logic  q0_illegal;
    word_t q1_instr;
    logic  q1_illegal;
    word_t q2_instr;
    logic  q2_illegal;

    modport q0_src (output q0_instr, output q0_illegal);
    modport q1_src (output q1_instr, output q1_illegal);
    modport q2_src (output q2_instr, output q2_illegal);

    modport sink (
        input q0_instr, input q0_illegal,
        input q1_instr, input q1_illegal,
        input q2_instr, input q2_illegal
    );

endinterface

`default_nettype wire

// File: rvc_expander_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander_asserts (
    input logic i_clk,
    input logic i_rst,
    input logic i_valid,
    input logic o_valid,
    input logic o_is_compressed,
    input logic o_illegal
);
    int fail_count = 0;

    // Fetch and issue registers in the valid path
    valid_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid == $past(i_valid, 2))
        else begin
            fail_count++;
            $error("o_valid does not follow i_valid by two cycles");
        end

    illegal_is_compressed: assert property (@(posedge i_clk)
        o_valid |-> (!o_illegal || o_is_compressed))
        else begin
            fail_count++;
            $error("o_illegal set on a word that is not compressed");
        end

    // Registers clear on the first edge inside reset
    quiet_in_reset: assert property (@(posedge i_clk) i_rst |=> !o_valid)
        else begin
            fail_count++;
            $error("o_valid high while reset is asserted");
        end

endmodule

bind rvc_expander_top rvc_expander_asserts u_asserts (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .o_valid         (o_valid),
    .o_is_compressed (o_is_compressed),
    .o_illegal       (o_illegal)
);

`default_nettype wire

// File: rvc_expander_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander_top (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_valid,
    input  rv32_pkg::word_t i_instr,
    output logic            o_valid,
    output rv32_pkg::word_t o_instr,
    output logic            o_is_compressed,
    output logic            o_illegal
);
    import rv32_pkg::*;

    logic  fetch_valid;
    word_t fetch_instr;

    rvc_expand_if u_exp_if ();

    rvc_fetch_stage u_fetch (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_instr (i_instr),
        .o_valid (fetch_valid),
        .o_instr (fetch_instr)
    );

    rvc_q0_expander u_q0 (.i_instr(fetch_instr), .exp(u_exp_if.q0_src));
    rvc_q1_expander u_q1 (.i_instr(fetch_instr), .exp(u_exp_if.q1_src));
    rvc_q2_expander u_q2 (.i_instr(fetch_instr), .exp(u_exp_if.q2_src));

    rvc_issue_stage u_issue (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_valid         (fetch_valid),
        .i_instr         (fetch_instr),
        .exp             (u_exp_if.sink),
        .o_valid         (o_valid),
        .o_is_compressed (o_is_compressed),
        .o_illegal       (o_illegal),
        .o_instr         (o_instr)
    );

endmodule

`default_nettype wire

// File: rvc_fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_fetch_stage (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_valid,
    input  rv32_pkg::word_t i_instr,
    output logic            o_valid,
    output rv32_pkg::word_t o_instr
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_instr <= i_instr; // Held until next word
        end
    end

endmodule

`default_nettype wire

// File: rvc_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_issue_stage (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_valid,
    input  rv32_pkg::word_t i_instr,
    rvc_expand_if.sink      exp,
    output logic            o_valid,
    output logic            o_is_compressed,
    output logic            o_illegal,
    output rv32_pkg::word_t o_instr
);
    import rv32_pkg::*;
    import rvc_pkg::*;

    quadrant_e quad;
    word_t     sel_instr;
    logic      sel_illegal;
    logic      sel_compressed;

    assign quad = quadrant_e'(i_instr[1:0]);

    always_comb begin
        sel_instr      = i_instr;
        sel_illegal    = 1'b0;
        sel_compressed = 1'b1;
        case (quad)
            Q0: begin
                sel_instr   = exp.q0_instr;
                sel_illegal = exp.q0_illegal;
            end
            Q1: begin
                sel_instr   = exp.q1_instr;
                sel_illegal = exp.q1_illegal;
            end
            Q2: begin
                sel_instr   = exp.q2_instr;
                sel_illegal = exp.q2_illegal;
            end
            UNCOMPRESSED: sel_compressed = 1'b0;
        endcase

        // All-zero word is a plain full-length word
        if (i_instr == '0) begin
            sel_compressed = 1'b0;
            sel_illegal    = 1'b0;
        end
        if (sel_illegal || !sel_compressed) begin
            sel_instr = i_instr; // Passthrough
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_instr         <= sel_instr;
            o_is_compressed <= sel_compressed;
            o_illegal       <= sel_illegal;
        end
    end

endmodule

`default_nettype wire

// File: rvc_pkg.sv
`default_nettype none

package rvc_pkg;

    typedef logic [15:0] half_t;
    typedef logic [2:0]  creg_t;

    localparam logic [1:0] CREG_BASE = 2'b01; // x8..x15

    typedef enum logic [1:0] {
        Q0           = 2'b00,
        Q1           = 2'b01,
        Q2           = 2'b10,
        UNCOMPRESSED = 2'b11
    } quadrant_e;

    typedef enum logic [2:0] {
        C_ADDI4SPN = 3'b000,
        C_LW       = 3'b010,
        C_SW       = 3'b110
    } q0_f3_e;

    typedef enum logic [2:0] {
        C_ADDI         = 3'b000,
        C_LI           = 3'b010,
        C_LUI_ADDI16SP = 3'b011,
        C_ALU          = 3'b100,
        C_J            = 3'b101,
        C_BEQZ         = 3'b110,
        C_BNEZ         = 3'b111
    } q1_f3_e;

    typedef enum logic [2:0] {
        C_SLLI      = 3'b000,
        C_LWSP      = 3'b010,
        C_JR_MV_ADD = 3'b100,
        C_SWSP      = 3'b110
    } q2_f3_e;

endpackage

`default_nettype wire

// File: rvc_q0_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_q0_expander (
    input  rv32_pkg::word_t i_instr,
    rvc_expand_if.q0_src    exp
);
    import rv32_pkg::*;
    import rvc_pkg::*;

    half_t  c;
    creg_t  rd_p;
    creg_t  rs1_p;
    q0_f3_e f3;

    assign c     = i_instr[15:0];
    assign rd_p  = c[4:2];  // Also rs2' for C.SW
    assign rs1_p = c[9:7];
    assign f3    = q0_f3_e'(c[15:13]);

    always_comb begin
        exp.q0_instr   = i_instr;
        exp.q0_illegal = 1'b0;
        case (f3)
            C_ADDI4SPN: begin
                exp.q0_instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                REG_SP, ADD_SUB, CREG_BASE, rd_p, OP_IMM};
                if (c[12:5] == 8'd0) begin
                    exp.q0_illegal = 1'b1; // Zero nzuimm is reserved
                end
            end
            C_LW: begin
                exp.q0_instr = {5'b0, c[5], c[12:10], c[6], 2'b00,
                                CREG_BASE, rs1_p, SLT_W, CREG_BASE, rd_p, LOAD};
            end
            C_SW: begin
                exp.q0_instr = {5'b0, c[5], c[12], CREG_BASE, rd_p, CREG_BASE, rs1_p,
                                SLT_W, c[11:10], c[6], 2'b00, STORE};
            end
            default: exp.q0_illegal = 1'b1; // FP and RV64 forms
        endcase
    end

endmodule

`default_nettype wire

// File: rvc_q1_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_q1_expander (
    input  rv32_pkg::word_t i_instr,
    rvc_expand_if.q1_src    exp
);
    import rv32_pkg::*;
    import rvc_pkg::*;

    half_t       c;
    creg_t       rs1_p;
    creg_t       rs2_p;
    logic [4:0]  rd;
    logic [11:0] imm6;
    q1_f3_e      f3;

    assign c     = i_instr[15:0];
    assign rs1_p = c[9:7];
    assign rs2_p = c[4:2];
    assign rd    = c[11:7];
    assign imm6  = {{6{c[12]}}, c[12], c[6:2]}; // Sign extended
    assign f3    = q1_f3_e'(c[15:13]);

    always_comb begin
        exp.q1_instr   = i_instr;
        exp.q1_illegal = 1'b0;
        case (f3)
            C_ADDI: exp.q1_instr = {imm6, rd, ADD_SUB, rd, OP_IMM};
            C_LI:   exp.q1_instr = {imm6, REG_ZERO, ADD_SUB, rd, OP_IMM};
            C_LUI_ADDI16SP: begin
                if (rd == REG_SP) begin
                    exp.q1_instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0,
                                    REG_SP, ADD_SUB, REG_SP, OP_IMM};
                end else if (rd != REG_ZERO) begin
                    exp.q1_instr = {{14{c[12]}}, c[12], c[6:2], rd, LUI};
                end
                // rd zero keeps the word as is
            end
            C_ALU: begin
                case (c[11:10])
                    2'b00: exp.q1_instr = {F7_BASE, c[6:2], CREG_BASE, rs1_p, SR,
                                           CREG_BASE, rs1_p, OP_IMM}; // SRLI
                    2'b01: exp.q1_instr = {F7_ALT, c[6:2], CREG_BASE, rs1_p, SR,
                                           CREG_BASE, rs1_p, OP_IMM}; // SRAI
                    2'b10: exp.q1_instr = {imm6, CREG_BASE, rs1_p, AND,
                                           CREG_BASE, rs1_p, OP_IMM}; // ANDI
                    default: begin
                        if (c[12]) begin
                            exp.q1_illegal = 1'b1; // SUBW/ADDW space
                        end else begin
                            case (c[6:5])
                                2'b00: exp.q1_instr = {F7_ALT, CREG_BASE, rs2_p, CREG_BASE,
                                                       rs1_p, ADD_SUB, CREG_BASE, rs1_p, OP};
                                2'b01: exp.q1_instr = {F7_BASE, CREG_BASE, rs2_p, CREG_BASE,
                                                       rs1_p, XOR, CREG_BASE, rs1_p, OP};
                                2'b10: exp.q1_instr = {F7_BASE, CREG_BASE, rs2_p, CREG_BASE,
                                                       rs1_p, OR, CREG_BASE, rs1_p, OP};
                                default: exp.q1_instr = {F7_BASE, CREG_BASE, rs2_p, CREG_BASE,
                                                         rs1_p, AND, CREG_BASE, rs1_p, OP};
                            endcase
                        end
                    end
                endcase
            end
            C_J: begin
                exp.q1_instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                {9{c[12]}}, REG_ZERO, JAL};
            end
            C_BEQZ: begin
                exp.q1_instr = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, CREG_BASE, rs1_p,
                                BEQ, c[11:10], c[4:3], c[12], BRANCH};
            end
            C_BNEZ: begin
                exp.q1_instr = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, CREG_BASE, rs1_p,
                                BNE, c[11:10], c[4:3], c[12], BRANCH};
            end
            default: exp.q1_illegal = 1'b1; // C.JAL / C.ADDIW code
        endcase
    end

endmodule

`default_nettype wire

// File: rvc_q2_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_q2_expander (
    input  rv32_pkg::word_t i_instr,
    rvc_expand_if.q2_src    exp
);
    import rv32_pkg::*;
    import rvc_pkg::*;

    half_t      c;
    logic [4:0] rd;
    logic [4:0] rs2;
    q2_f3_e     f3;

    assign c   = i_instr[15:0];
    assign rd  = c[11:7];
    assign rs2 = c[6:2];
    assign f3  = q2_f3_e'(c[15:13]);

    always_comb begin
        exp.q2_instr   = i_instr;
        exp.q2_illegal = 1'b0;
        case (f3)
            C_SLLI: exp.q2_instr = {F7_BASE, rs2, rd, SLL, rd, OP_IMM};
            C_LWSP: begin
                exp.q2_instr = {4'b0, c[3:2], c[12], c[6:4], 2'b00,
                                REG_SP, SLT_W, rd, LOAD};
            end
            C_SWSP: begin
                exp.q2_instr = {4'b0, c[8:7], c[12], rs2, REG_SP, SLT_W,
                                c[11:9], 2'b00, STORE};
            end
            C_JR_MV_ADD: begin
                if (!c[12]) begin
                    if (rs2 == REG_ZERO) begin
                        exp.q2_instr = {12'b0, rd, ADD_SUB, REG_ZERO, JALR}; // JR
                    end else begin
                        exp.q2_instr = {F7_BASE, rs2, REG_ZERO, ADD_SUB, rd, OP}; // MV
                    end
                    if (rd == REG_ZERO) begin
                        exp.q2_illegal = 1'b1;
                    end
                end else if (c[11:2] == 10'd0) begin
                    exp.q2_instr = EBREAK_WORD;
                end else if (rs2 == REG_ZERO) begin
                    exp.q2_instr = {12'b0, rd, ADD_SUB, REG_RA, JALR}; // Link in ra
                end else begin
                    exp.q2_instr = {F7_BASE, rs2, rd, ADD_SUB, rd, OP}; // ADD
                end
            end
            default: exp.q2_illegal = 1'b1; // FP and RV64 stack forms
        endcase
    end

endmodule

`default_nettype wire

// File: tb_rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvc_expander;
    import rv32_pkg::*;

    localparam int NUM_RANDOM  = 24;
    localparam int DRAIN_LIMIT = 20;

    logic  i_clk;
    logic  i_rst;
    logic  i_valid;
    word_t i_instr;
    logic  o_valid;
    word_t o_instr;
    logic  o_is_compressed;
    logic  o_illegal;
    int    checked;
    int    errors;

    string row_name[$];
    word_t row_in[$];
    word_t row_out[$];
    logic  row_comp[$];
    logic  row_ill[$];

    rvc_expander_top uut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_valid         (i_valid),
        .i_instr         (i_instr),
        .o_valid         (o_valid),
        .o_instr         (o_instr),
        .o_is_compressed (o_is_compressed),
        .o_illegal       (o_illegal)
    );

    rvc_checker u_chk (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_valid         (o_valid),
        .i_instr         (o_instr),
        .i_is_compressed (o_is_compressed),
        .i_illegal       (o_illegal),
        .o_checked       (checked),
        .o_errors        (errors)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input string name, input word_t in_w, input word_t out_w,
                           input logic comp, input logic ill);
        row_name.push_back(name);
        row_in.push_back(in_w);
        row_out.push_back(out_w);
        row_comp.push_back(comp);
        row_ill.push_back(ill);
    endtask

    // Input word, expected word, is_compressed, illegal
    task automatic load_table();
        add_row("addi4spn 4",   32'h0000_0040, 32'h0041_0413, 1'b1, 1'b0);
        add_row("addi4spn max", 32'h0000_1FE4, 32'h3FC1_0493, 1'b1, 1'b0);
        add_row("addi4spn 0",   32'h0000_0004, 32'h0000_0004, 1'b1, 1'b1);
        add_row("lw",           32'h0000_4164, 32'h0445_2483, 1'b1, 1'b0);
        add_row("sw",           32'h0000_DE6C, 32'h06B6_2E23, 1'b1, 1'b0);
        add_row("q0 f3=011",    32'h1234_6000, 32'h1234_6000, 1'b1, 1'b1);
        add_row("q0 f3=101",    32'h0000_A004, 32'h0000_A004, 1'b1, 1'b1);
        add_row("q0 f3=111",    32'h0000_E008, 32'h0000_E008, 1'b1, 1'b1);
        add_row("q0 low zero",  32'h1234_0000, 32'h1234_0000, 1'b1, 1'b1);
        add_row("nop hi bits",  32'hDEAD_0001, 32'h0000_0013, 1'b1, 1'b0);
        add_row("addi +3",      32'h0000_028D, 32'h0032_8293, 1'b1, 1'b0);
        add_row("addi -1",      32'h0000_12FD, 32'hFFF2_8293, 1'b1, 1'b0);
        add_row("li -5",        32'h0000_556D, 32'hFFB0_0513, 1'b1, 1'b0);
        add_row("li +31",       32'h0000_40FD, 32'h01F0_0093, 1'b1, 1'b0);
        add_row("lui +",        32'h0000_61FD, 32'h0001_F1B7, 1'b1, 1'b0);
        add_row("lui -",        32'h0000_7181, 32'hFFFE_01B7, 1'b1, 1'b0);
        add_row("lui rd=0",     32'h0000_6005, 32'h0000_6005, 1'b1, 1'b0);
        add_row("addi16sp +16", 32'h0000_6141, 32'h0101_0113, 1'b1, 1'b0);
        add_row("addi16sp -32", 32'h0000_713D, 32'hFE01_0113, 1'b1, 1'b0);
        add_row("srli",         32'h0000_8015, 32'h0054_5413, 1'b1, 1'b0);
        add_row("srai",         32'h0000_84FD, 32'h41F4_D493, 1'b1, 1'b0);
        add_row("andi -2",      32'h0000_9979, 32'hFFE5_7513, 1'b1, 1'b0);
        add_row("sub",          32'h0000_8C05, 32'h4094_0433, 1'b1, 1'b0);
        add_row("xor",          32'h0000_8D2D, 32'h00B5_4533, 1'b1, 1'b0);
        add_row("or",           32'h0000_8E55, 32'h00D6_6633, 1'b1, 1'b0);
        add_row("and",          32'h0000_8F7D, 32'h00F7_7733, 1'b1, 1'b0);
        add_row("alu bit12",    32'h0000_9C05, 32'h0000_9C05, 1'b1, 1'b1);
        add_row("j -16",        32'h0000_BFC5, 32'hFF1F_F06F, 1'b1, 1'b0);
        add_row("beqz -4",      32'h0000_DC75, 32'hFE04_0EE3, 1'b1, 1'b0);
        add_row("bnez -8",      32'h0000_FCE5, 32'hFE04_9CE3, 1'b1, 1'b0);
        add_row("q1 f3=001",    32'h0000_2001, 32'h0000_2001, 1'b1, 1'b1);
        add_row("slli",         32'h0000_028E, 32'h0032_9293, 1'b1, 1'b0);
        add_row("lwsp",         32'h0000_50FE, 32'h0FC1_2083, 1'b1, 1'b0);
        add_row("swsp",         32'h0000_C422, 32'h0081_2423, 1'b1, 1'b0);
        add_row("jr",           32'h0000_8082, 32'h0000_8067, 1'b1, 1'b0);
        add_row("mv",           32'h0000_852E, 32'h00B0_0533, 1'b1, 1'b0);
        add_row("ebreak",       32'h0000_9002, 32'h0010_0073, 1'b1, 1'b0);
        add_row("jalr",         32'h0000_9282, 32'h0002_80E7, 1'b1, 1'b0);
        add_row("add",          32'h0000_952E, 32'h00B5_0533, 1'b1, 1'b0);
        add_row("jr rd=0",      32'h0000_8002, 32'h0000_8002, 1'b1, 1'b1);
        add_row("mv rd=0",      32'h0000_8016, 32'h0000_8016, 1'b1, 1'b1);
        add_row("q2 f3=011",    32'h0000_6082, 32'h0000_6082, 1'b1, 1'b1);
        add_row("q2 f3=111",    32'h0000_E006, 32'h0000_E006, 1'b1, 1'b1);
        add_row("all zero",     32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
        add_row("full add",     32'h00A5_0533, 32'h00A5_0533, 1'b0, 1'b0);
    endtask

    task automatic apply_word(input string name, input word_t in_w, input word_t out_w,
                              input logic comp, input logic ill);
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_instr <= in_w;
        u_chk.expect_word(name, out_w, comp, ill);
    endtask

    initial begin
        int          applied;
        int          drain;
        int          total;
        bit          timed_out;
        logic [31:0] seed;
        word_t       rnd;
        i_rst   = 1'b1;
        i_valid = 1'b1; // Words offered during reset must be dropped
        i_instr = 32'h0000_0001;
        applied = 0;
        load_table();
        repeat (2) @(posedge i_clk);
        i_valid <= 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (3) @(posedge i_clk); // Idle, o_valid must stay low

        for (int i = 0; i < row_in.size(); i++) begin
            apply_word(row_name[i], row_in[i], row_out[i], row_comp[i], row_ill[i]);
            applied++;
        end

        // Full-length words back to back, expected unchanged
        seed = 32'd14554;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            seed = xorshift32(seed);
            rnd  = {seed[31:2], 2'b11};
            apply_word("random", rnd, rnd, 1'b0, 1'b0);
            applied++;
        end
        @(posedge i_clk);
        i_valid <= 1'b0;

        drain = 0;
        while (checked < applied && drain < DRAIN_LIMIT) begin
            @(posedge i_clk);
            drain++;
        end
        repeat (4) @(posedge i_clk); // Catch stray output pulses

        timed_out = (checked < applied);
        if (timed_out) begin
            $display("Timeout: only %0d of %0d words came out of the DUT", checked, applied);
        end
        total = errors + uut.u_asserts.fail_count + (timed_out ? 1 : 0);
        $display("Summary: %0d words checked, %0d errors, %0d assertion failures",
                 checked, errors, uut.u_asserts.fail_count);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
